// File: Makefile
# Verilator flow for the Wishbone peripheral subsystem

VERILATOR ?= verilator
FLIST     ?= compile.f
TB_TOP    ?= soc_tb
RTL_TOP   ?= soc_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: compile.f
src/soc_pkg.sv
src/sync_fifo.sv
src/wb_addr_decode.sv
src/wb_data_resize.sv
src/gpio_regs.sv
src/wb_fifo.sv
src/soc_top.sv
sim/soc_chk.sv
sim/soc_tb.sv

// File: sim/soc_chk.sv
`default_nettype none

module soc_chk (
	input wire                      wb_clk_i,
	input wire                      arst_n_i,
	input wire                      wb_cyc_i,
	input wire                      wb_stb_i,
	input wire [soc_pkg::WB_AW-1:0] wb_adr_i,
	input wire                      wb_ack_i,
	input wire                      wb_err_i
);

	logic       idle;
	logic       accept;
	logic       acc_mapped;
	logic [7:0] region;

	assign region     = wb_adr_i[soc_pkg::REGION_MSB:soc_pkg::REGION_LSB];
	assign accept     = idle & wb_cyc_i & wb_stb_i;
	assign acc_mapped = accept &
		((region == soc_pkg::GPIO_REGION) | (region == soc_pkg::FIFO_REGION));

	// One transfer at a time, as seen on the slave port
	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i)
			idle <= 1'b1;
		else if (accept)
			idle <= 1'b0;
		else if (wb_ack_i || wb_err_i)
			idle <= 1'b1;
	end

	ack_err_excl: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
		!(wb_ack_i && wb_err_i))
		else $error("ack and err high in the same cycle");

	answer_in_cycle: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
		(wb_ack_i || wb_err_i) |-> (wb_cyc_i && wb_stb_i))
		else $error("answer without cyc and stb");

	ack_latency: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
		$past(acc_mapped, 2) == wb_ack_i)
		else $error("ack not 2 cycles after a mapped request");

endmodule

bind soc_top soc_chk u_chk (
	.wb_clk_i (wb_clk_i),
	.arst_n_i (arst_n_i),
	.wb_cyc_i (wb_cyc_i),
	.wb_stb_i (wb_stb_i),
	.wb_adr_i (wb_adr_i),
	.wb_ack_i (wb_ack_o),
	.wb_err_i (wb_err_o)
);

`default_nettype wire

// File: sim/soc_tb.sv
`default_nettype none

module soc_tb;

	localparam int ANSWER_WAIT = 4;
	// About 41 bus transfers of 4 cycles and 23 FIFO pulses of 2 cycles with wide margin
	localparam int MAX_CYCLES  = 2000;

	logic                       wb_clk;
	logic                       arst_n;
	logic                       wb_cyc;
	logic                       wb_stb;
	logic                       wb_we;
	logic [soc_pkg::WB_AW-1:0]  wb_adr;
	logic [soc_pkg::WB_SW-1:0]  wb_sel;
	soc_pkg::wb_word_u          wb_wdat;
	soc_pkg::wb_word_u          wb_rdat;
	logic                       wb_ack;
	logic                       wb_err;
	logic [soc_pkg::GPIO_W-1:0] gpio_in;
	logic [soc_pkg::GPIO_W-1:0] gpio_out;
	logic [soc_pkg::GPIO_W-1:0] gpio_oe;
	logic [soc_pkg::WB_DW-1:0]  s2m_dat;
	logic                       s2m_we;
	logic                       s2m_empty;
	logic                       s2m_full;
	logic [soc_pkg::WB_DW-1:0]  m2s_dat;
	logic                       m2s_re;
	logic                       m2s_empty;
	logic                       m2s_full;

	// Reference state kept from the register and FIFO rules
	logic [soc_pkg::GPIO_W-1:0] dir_model;
	logic [soc_pkg::GPIO_W-1:0] out_model;
	logic [soc_pkg::WB_DW-1:0]  m2s_q [$];
	logic [soc_pkg::WB_DW-1:0]  s2m_q [$];

	integer seed = 32'hd9aa3267;
	int     checks;
	int     value_errs;
	int     other_errs;

	soc_top dut (
		.wb_clk_i          (wb_clk),
		.arst_n_i          (arst_n),
		.wb_cyc_i          (wb_cyc),
		.wb_stb_i          (wb_stb),
		.wb_we_i           (wb_we),
		.wb_adr_i          (wb_adr),
		.wb_sel_i          (wb_sel),
		.wb_dat_i          (wb_wdat),
		.wb_dat_o          (wb_rdat),
		.wb_ack_o          (wb_ack),
		.wb_err_o          (wb_err),
		.gpio_i            (gpio_in),
		.gpio_o            (gpio_out),
		.gpio_oe_o         (gpio_oe),
		.fifo0_s2m_dat_i   (s2m_dat),
		.fifo0_s2m_we_i    (s2m_we),
		.fifo0_s2m_empty_o (s2m_empty),
		.fifo0_s2m_full_o  (s2m_full),
		.fifo0_m2s_dat_o   (m2s_dat),
		.fifo0_m2s_re_i    (m2s_re),
		.fifo0_m2s_empty_o (m2s_empty),
		.fifo0_m2s_full_o  (m2s_full)
	);

	always #2 wb_clk = ~wb_clk;

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////
	task automatic check_word(input string name, input soc_pkg::wb_word_u got,
		input soc_pkg::wb_word_u exp);
		checks++;
		if (got !== exp) begin
			value_errs++;
			$display("FAIL %s: got %h, expected %h", name, got.word, exp.word);
		end
	endtask

	task automatic check_byte(input string name, input logic [soc_pkg::GPIO_W-1:0] got,
		input logic [soc_pkg::GPIO_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			value_errs++;
			$display("FAIL %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			value_errs++;
			$display("FAIL %s: got %h, expected %h", name, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Address and expected value helpers
	////////////////////////////////////////////////////////////
	function automatic logic [31:0] gpio_adr(input logic [7:0] ofs);
		return {soc_pkg::GPIO_REGION, 16'h0, ofs[7:2], 2'b00};
	endfunction

	function automatic logic [3:0] lane_sel(input logic [7:0] ofs);
		return 4'b0001 << ofs[1:0];
	endfunction

	function automatic logic [31:0] fifo_adr(input logic [5:0] ofs);
		return {soc_pkg::FIFO_REGION, 16'h0, ofs, 2'b00};
	endfunction

	function automatic soc_pkg::wb_word_u all_lanes(input logic [7:0] b);
		soc_pkg::wb_word_u w;
		for (int i = 0; i < soc_pkg::WB_SW; i++)
			w.lane[i] = b;
		return w;
	endfunction

	// Output bit where the pin is driven, input bit where it is not
	function automatic logic [soc_pkg::GPIO_W-1:0] pins_expect();
		logic [soc_pkg::GPIO_W-1:0] b;
		for (int i = 0; i < soc_pkg::GPIO_W; i++) begin
			if (dir_model[i])
				b[i] = out_model[i];
			else
				b[i] = gpio_in[i];
		end
		return b;
	endfunction

	function automatic soc_pkg::wb_word_u stat_expect();
		soc_pkg::wb_word_u w;
		w.word = '0;
		w.word[soc_pkg::STAT_S2M_EMPTY] = (s2m_q.size() == 0);
		w.word[soc_pkg::STAT_S2M_FULL]  = (s2m_q.size() == soc_pkg::FIFO_DEPTH);
		w.word[soc_pkg::STAT_M2S_EMPTY] = (m2s_q.size() == 0);
		w.word[soc_pkg::STAT_M2S_FULL]  = (m2s_q.size() == soc_pkg::FIFO_DEPTH);
		return w;
	endfunction

	////////////////////////////////////////////////////////////
	// Bus master
	////////////////////////////////////////////////////////////
	// Answers are sampled at the falling edge
	task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [3:0] sel,
		input soc_pkg::wb_word_u wdat, output logic got_ack, output logic got_err,
		output soc_pkg::wb_word_u rdat);
		int n;
		@(posedge wb_clk);
		#1;
		wb_cyc  = 1'b1;
		wb_stb  = 1'b1;
		wb_we   = we;
		wb_adr  = adr;
		wb_sel  = sel;
		wb_wdat = wdat;
		got_ack = 1'b0;
		got_err = 1'b0;
		rdat.word = '0;
		n = 0;
		while (!got_ack && !got_err && n < ANSWER_WAIT) begin
			@(negedge wb_clk);
			got_ack = wb_ack;
			got_err = wb_err;
			rdat    = wb_rdat;
			n++;
		end
		@(posedge wb_clk);
		#1;
		wb_cyc = 1'b0; // Drop the request after the answer
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic bus_write(input logic [31:0] adr, input logic [3:0] sel,
		input soc_pkg::wb_word_u wdat);
		logic              ack;
		logic              err;
		soc_pkg::wb_word_u rdat;
		bus_cycle(1'b1, adr, sel, wdat, ack, err, rdat);
		if (!ack || err) begin
			other_errs++;
			$display("Write to %h was not acknowledged within %0d cycles", adr, ANSWER_WAIT);
		end
	endtask

	task automatic bus_read(input logic [31:0] adr, input logic [3:0] sel,
		output soc_pkg::wb_word_u rdat);
		logic              ack;
		logic              err;
		soc_pkg::wb_word_u wdat;
		wdat.word = $random(seed); // Ignored by the slave on reads
		bus_cycle(1'b0, adr, sel, wdat, ack, err, rdat);
		if (!ack || err) begin
			other_errs++;
			$display("Read from %h was not acknowledged within %0d cycles", adr, ANSWER_WAIT);
		end
	endtask

	task automatic bus_write_expect_err(input logic [31:0] adr, input logic [3:0] sel,
		input soc_pkg::wb_word_u wdat);
		logic              ack;
		logic              err;
		soc_pkg::wb_word_u rdat;
		bus_cycle(1'b1, adr, sel, wdat, ack, err, rdat);
		if (!err || ack) begin
			other_errs++;
			$display("Write to unmapped %h did not end with an error alone", adr);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Peripheral access
	////////////////////////////////////////////////////////////
	task automatic gpio_write(input logic [7:0] ofs, input logic [7:0] b);
		soc_pkg::wb_word_u w;
		w.word = $random(seed); // Junk on the unselected lanes
		w.lane[ofs[1:0]] = b;
		bus_write(gpio_adr(ofs), lane_sel(ofs), w);
		if (ofs == soc_pkg::GPIO_REG_DIR)
			dir_model = b;
		else
			out_model = b;
	endtask

	task automatic fifo_write(input logic [31:0] d);
		soc_pkg::wb_word_u w;
		w.word = d;
		bus_write(fifo_adr(soc_pkg::FIFO_REG_DATA), 4'hf, w);
		if (m2s_q.size() < soc_pkg::FIFO_DEPTH)
			m2s_q.push_back(d);
	endtask

	task automatic check_status();
		soc_pkg::wb_word_u rd;
		bus_read(fifo_adr(soc_pkg::FIFO_REG_STAT), 4'hf, rd);
		check_word("wb_dat_o (status)", rd, stat_expect());
	endtask

	task automatic fifo_read_data();
		soc_pkg::wb_word_u rd;
		soc_pkg::wb_word_u exp;
		exp.word = '0; // Empty FIFO reads as 0
		if (s2m_q.size() > 0)
			exp.word = s2m_q.pop_front();
		bus_read(fifo_adr(soc_pkg::FIFO_REG_DATA), 4'hf, rd);
		check_word("wb_dat_o (s2m data)", rd, exp);
	endtask

	task automatic s2m_push(input logic [31:0] d);
		@(posedge wb_clk);
		#1;
		s2m_we  = 1'b1;
		s2m_dat = d;
		@(posedge wb_clk);
		#1;
		s2m_we  = 1'b0;
		if (s2m_q.size() < soc_pkg::FIFO_DEPTH)
			s2m_q.push_back(d);
	endtask

	task automatic m2s_drain();
		soc_pkg::wb_word_u exp;
		while (m2s_q.size() > 0) begin
			exp.word = m2s_q.pop_front();
			check_word("fifo0_m2s_dat_o", m2s_dat, exp); // Head shown ahead of the pop
			@(posedge wb_clk);
			#1;
			m2s_re = 1'b1;
			@(posedge wb_clk);
			#1;
			m2s_re = 1'b0;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////
	task automatic test_gpio_out();
		soc_pkg::wb_word_u rd;
		gpio_write(soc_pkg::GPIO_REG_DIR, 8'($random(seed)));
		gpio_write(soc_pkg::GPIO_REG_DATA, 8'($random(seed)));
		check_byte("gpio_oe_o", gpio_oe, dir_model);
		check_byte("gpio_o", gpio_out, out_model);
		bus_read(gpio_adr(soc_pkg::GPIO_REG_DIR), lane_sel(soc_pkg::GPIO_REG_DIR), rd);
		check_word("wb_dat_o (gpio dir)", rd, all_lanes(dir_model));
	endtask

	task automatic test_gpio_pins();
		soc_pkg::wb_word_u rd;
		logic [7:0]        dir;
		dir = 8'($random(seed));
		if (dir == 8'h00 || dir == 8'hff)
			dir = 8'h5a; // Keep both directions in use
		gpio_write(soc_pkg::GPIO_REG_DIR, dir);
		gpio_write(soc_pkg::GPIO_REG_DATA, 8'($random(seed)));
		gpio_in = 8'($random(seed));
		bus_read(gpio_adr(soc_pkg::GPIO_REG_DATA), lane_sel(soc_pkg::GPIO_REG_DATA), rd);
		check_word("wb_dat_o (gpio pins)", rd, all_lanes(pins_expect()));
	endtask

	task automatic test_fifo_m2s();
		for (int i = 0; i < 3; i++)
			fifo_write($random(seed));
		check_bit("fifo0_m2s_empty_o", m2s_empty, 1'b0);
		m2s_drain();
		check_bit("fifo0_m2s_empty_o", m2s_empty, 1'b1);
		for (int i = 0; i <= soc_pkg::FIFO_DEPTH; i++)
			fifo_write($random(seed)); // Last one lands on a full FIFO
		check_bit("fifo0_m2s_full_o", m2s_full, 1'b1);
		check_status();
		m2s_drain();
		check_bit("fifo0_m2s_empty_o", m2s_empty, 1'b1);
		check_bit("fifo0_m2s_full_o", m2s_full, 1'b0);
	endtask

	task automatic test_fifo_s2m();
		check_status();
		for (int i = 0; i < 3; i++)
			s2m_push($random(seed));
		check_status();
		for (int i = 0; i < 3; i++)
			fifo_read_data();
		check_status();
		fifo_read_data();
		for (int i = 0; i <= soc_pkg::FIFO_DEPTH; i++)
			s2m_push($random(seed));
		check_bit("fifo0_s2m_full_o", s2m_full, 1'b1);
		check_status();
		for (int i = 0; i <= soc_pkg::FIFO_DEPTH; i++)
			fifo_read_data(); // One extra read finds it empty
		check_bit("fifo0_s2m_empty_o", s2m_empty, 1'b1);
	endtask

	task automatic test_unmapped();
		soc_pkg::wb_word_u w;
		soc_pkg::wb_word_u rd;
		w.word = $random(seed);
		bus_write_expect_err({8'h50, 24'h000000}, 4'hf, w);
		bus_write_expect_err({8'h50, 24'h000004}, 4'hf, w);
		check_byte("gpio_o", gpio_out, out_model);
		check_byte("gpio_oe_o", gpio_oe, dir_model);
		bus_read(gpio_adr(soc_pkg::GPIO_REG_DIR), lane_sel(soc_pkg::GPIO_REG_DIR), rd);
		check_word("wb_dat_o (gpio dir)", rd, all_lanes(dir_model));
		check_status();
	endtask

	initial begin
		repeat (MAX_CYCLES) @(posedge wb_clk);
		$display("Run stopped by the watchdog after %0d cycles", MAX_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		wb_clk    = 1'b0;
		arst_n    = 1'b0;
		wb_cyc    = 1'b0;
		wb_stb    = 1'b0;
		wb_we     = 1'b0;
		wb_adr    = '0;
		wb_sel    = '0;
		wb_wdat   = '0;
		gpio_in   = '0;
		s2m_dat   = '0;
		s2m_we    = 1'b0;
		m2s_re    = 1'b0;
		dir_model = '0;
		out_model = '0;
		repeat (10) @(posedge wb_clk);
		#1;
		arst_n = 1'b1;
		check_bit("wb_ack_o", wb_ack, 1'b0);
		check_bit("wb_err_o", wb_err, 1'b0);
		check_bit("fifo0_s2m_empty_o", s2m_empty, 1'b1);
		check_bit("fifo0_m2s_empty_o", m2s_empty, 1'b1);
		check_bit("fifo0_s2m_full_o", s2m_full, 1'b0);
		check_bit("fifo0_m2s_full_o", m2s_full, 1'b0);
		check_byte("gpio_oe_o", gpio_oe, 8'h00);
		check_byte("gpio_o", gpio_out, 8'h00);
		test_gpio_out();
		test_gpio_pins();
		test_fifo_m2s();
		test_fifo_s2m();
		test_unmapped();
		$display("Checks %0d, value errors %0d, other errors %0d",
			checks, value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/gpio_regs.sv
`default_nettype none

module gpio_regs (
	input  wire                           wb_clk_i,
	input  wire                           arst_n_i,
	input  wire                           adr_i,
	input  wire [soc_pkg::GPIO_W-1:0]     dat_i,
	input  wire                           we_i,
	input  wire                           stb_i,
	output logic [soc_pkg::GPIO_W-1:0]    dat_o,
	output logic                          ack_o,
	// Pins
	input  wire [soc_pkg::GPIO_W-1:0]     gpio_i,
	output logic [soc_pkg::GPIO_W-1:0]    gpio_o,
	output logic [soc_pkg::GPIO_W-1:0]    gpio_oe_o
);

	logic                       access;
	logic                       sel_dir;
	logic [soc_pkg::GPIO_W-1:0] pin_val;

	assign access  = stb_i & ~ack_o; // Once per request
	assign sel_dir = (adr_i == soc_pkg::GPIO_REG_DIR[0]);

	// Driven pins read back their own output
	assign pin_val = (gpio_o & gpio_oe_o) | (gpio_i & ~gpio_oe_o);

	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_o     <= 1'b0;
			gpio_o    <= '0;
			gpio_oe_o <= '0; // All pins inputs
		end else begin
			ack_o <= access;
			if (access && we_i) begin
				if (sel_dir)
					gpio_oe_o <= dat_i;
				else
					gpio_o <= dat_i;
			end
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (access && !we_i)
			dat_o <= sel_dir ? gpio_oe_o : pin_val;
	end

endmodule

`default_nettype wire

// File: src/soc_pkg.sv
`default_nettype none

package soc_pkg;

	////////////////////////////////////////////////////////////
	// Bus geometry
	////////////////////////////////////////////////////////////
	localparam int WB_DW      = 32;
	localparam int WB_AW      = 32;
	localparam int WB_SW      = 4; // One select bit per byte lane
	localparam int GPIO_W     = 8;
	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_PTR_W = 3;

	////////////////////////////////////////////////////////////
	// Address map
	////////////////////////////////////////////////////////////
	localparam int REGION_MSB = 31;
	localparam int REGION_LSB = 24;

	localparam logic [7:0] GPIO_REGION = 8'h91;
	localparam logic [7:0] FIFO_REGION = 8'h92;

	// GPIO registers, byte offsets within the region
	localparam logic [7:0] GPIO_REG_DATA = 8'd0;
	localparam logic [7:0] GPIO_REG_DIR  = 8'd1;

	// FIFO bridge registers, word offsets within the region
	localparam logic [5:0] FIFO_REG_DATA = 6'd0;
	localparam logic [5:0] FIFO_REG_STAT = 6'd1;

	// Status register bit positions
	localparam int STAT_S2M_EMPTY = 0;
	localparam int STAT_S2M_FULL  = 1;
	localparam int STAT_M2S_EMPTY = 2;
	localparam int STAT_M2S_FULL  = 3;

	// Data word, seen whole or as byte lanes (lane 0 lowest)
	typedef union packed {
		logic [WB_DW-1:0]             word;
		logic [WB_SW-1:0][GPIO_W-1:0] lane;
	} wb_word_u;

endpackage

`default_nettype wire

// File: src/soc_top.sv
`default_nettype none

module soc_top (
	input  wire                          wb_clk_i,
	input  wire                          arst_n_i,
	// Wishbone slave port
	input  wire                          wb_cyc_i,
	input  wire                          wb_stb_i,
	input  wire                          wb_we_i,
	input  wire [soc_pkg::WB_AW-1:0]     wb_adr_i,
	input  wire [soc_pkg::WB_SW-1:0]     wb_sel_i,
	input  wire soc_pkg::wb_word_u       wb_dat_i,
	output soc_pkg::wb_word_u            wb_dat_o,
	output logic                         wb_ack_o,
	output logic                         wb_err_o,
	// GPIO pins
	input  wire [soc_pkg::GPIO_W-1:0]    gpio_i,
	output logic [soc_pkg::GPIO_W-1:0]   gpio_o,
	output logic [soc_pkg::GPIO_W-1:0]   gpio_oe_o,
	// FIFO bridge
	input  wire [soc_pkg::WB_DW-1:0]     fifo0_s2m_dat_i,
	input  wire                          fifo0_s2m_we_i,
	output logic                         fifo0_s2m_empty_o,
	output logic                         fifo0_s2m_full_o,
	output logic [soc_pkg::WB_DW-1:0]    fifo0_m2s_dat_o,
	input  wire                          fifo0_m2s_re_i,
	output logic                         fifo0_m2s_empty_o,
	output logic                         fifo0_m2s_full_o
);

	// Registered request
	logic [soc_pkg::WB_AW-1:0] req_adr;
	logic [soc_pkg::WB_SW-1:0] req_sel;
	logic                      req_we;
	soc_pkg::wb_word_u         req_dat;
	logic                      gpio_stb;
	logic                      fifo_stb;

	// Responses
	logic                      gpio_ack;
	soc_pkg::wb_word_u         gpio_dat;
	logic                      fifo_ack;
	soc_pkg::wb_word_u         fifo_dat;

	// 8-bit GPIO bus
	logic                       gpio8_adr;
	logic [soc_pkg::GPIO_W-1:0] gpio8_wdat;
	logic [soc_pkg::GPIO_W-1:0] gpio8_rdat;
	logic                       gpio8_we;
	logic                       gpio8_stb;
	logic                       gpio8_ack;

	wb_addr_decode u_decode (
		.wb_clk_i   (wb_clk_i),
		.arst_n_i   (arst_n_i),
		.wb_cyc_i   (wb_cyc_i),
		.wb_stb_i   (wb_stb_i),
		.wb_we_i    (wb_we_i),
		.wb_adr_i   (wb_adr_i),
		.wb_sel_i   (wb_sel_i),
		.wb_dat_i   (wb_dat_i),
		.wb_ack_o   (wb_ack_o),
		.wb_err_o   (wb_err_o),
		.wb_dat_o   (wb_dat_o),
		.gpio_ack_i (gpio_ack),
		.fifo_ack_i (fifo_ack),
		.gpio_dat_i (gpio_dat),
		.fifo_dat_i (fifo_dat),
		.req_adr_o  (req_adr),
		.req_sel_o  (req_sel),
		.req_we_o   (req_we),
		.req_dat_o  (req_dat),
		.gpio_stb_o (gpio_stb),
		.fifo_stb_o (fifo_stb)
	);

	////////////////////////////////////////////////////////////
	// GPIO behind the 32 to 8 bit resize
	////////////////////////////////////////////////////////////
	wb_data_resize u_resize_gpio (
		.adr_i        (req_adr),
		.sel_i        (req_sel),
		.dat_i        (req_dat),
		.we_i         (req_we),
		.stb_i        (gpio_stb),
		.dat_o        (gpio_dat),
		.ack_o        (gpio_ack),
		.narrow_dat_i (gpio8_rdat),
		.narrow_ack_i (gpio8_ack),
		.narrow_adr_o (gpio8_adr),
		.narrow_dat_o (gpio8_wdat),
		.narrow_we_o  (gpio8_we),
		.narrow_stb_o (gpio8_stb)
	);

	gpio_regs u_gpio (
		.wb_clk_i  (wb_clk_i),
		.arst_n_i  (arst_n_i),
		.adr_i     (gpio8_adr),
		.dat_i     (gpio8_wdat),
		.we_i      (gpio8_we),
		.stb_i     (gpio8_stb),
		.dat_o     (gpio8_rdat),
		.ack_o     (gpio8_ack),
		.gpio_i    (gpio_i),
		.gpio_o    (gpio_o),
		.gpio_oe_o (gpio_oe_o)
	);

	wb_fifo u_fifo0 (
		.wb_clk_i    (wb_clk_i),
		.arst_n_i    (arst_n_i),
		.adr_i       (req_adr),
		.dat_i       (req_dat),
		.we_i        (req_we),
		.stb_i       (fifo_stb),
		.dat_o       (fifo_dat),
		.ack_o       (fifo_ack),
		.s2m_dat_i   (fifo0_s2m_dat_i),
		.s2m_we_i    (fifo0_s2m_we_i),
		.s2m_empty_o (fifo0_s2m_empty_o),
		.s2m_full_o  (fifo0_s2m_full_o),
		.m2s_re_i    (fifo0_m2s_re_i),
		.m2s_dat_o   (fifo0_m2s_dat_o),
		.m2s_empty_o (fifo0_m2s_empty_o),
		.m2s_full_o  (fifo0_m2s_full_o)
	);

endmodule

`default_nettype wire

// File: src/sync_fifo.sv
`default_nettype none

module sync_fifo (
	input  wire                      wb_clk_i,
	input  wire                      arst_n_i,
	input  wire                      wr_i,
	input  wire soc_pkg::wb_word_u   wr_dat_i,
	input  wire                      rd_i,
	output soc_pkg::wb_word_u        rd_dat_o,
	output logic                     empty_o,
	output logic                     full_o
);

	localparam int PTR_W = soc_pkg::FIFO_PTR_W;

	soc_pkg::wb_word_u mem [soc_pkg::FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             wr_ok;
	logic             rd_ok;

	assign wr_ok = wr_i & ~full_o;  // Drop when full
	assign rd_ok = rd_i & ~empty_o; // No pop when empty

	assign empty_o = (count == '0);
	assign full_o  = (count == (PTR_W + 1)'(soc_pkg::FIFO_DEPTH));

	////////////////////////////////////////////////////////////
	// Pointers and fill level
	////////////////////////////////////////////////////////////
	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1; // Wraps at depth
			if (rd_ok)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_ok, rd_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (wr_ok)
			mem[wr_ptr] <= wr_dat_i;
	end

	// Show-ahead head entry
	assign rd_dat_o = mem[rd_ptr];

endmodule

`default_nettype wire

// File: src/wb_addr_decode.sv
`default_nettype none

module wb_addr_decode (
	input  wire                          wb_clk_i,
	input  wire                          arst_n_i,
	// Master side
	input  wire                          wb_cyc_i,
	input  wire                          wb_stb_i,
	input  wire                          wb_we_i,
	input  wire [soc_pkg::WB_AW-1:0]     wb_adr_i,
	input  wire [soc_pkg::WB_SW-1:0]     wb_sel_i,
	input  wire soc_pkg::wb_word_u       wb_dat_i,
	output logic                         wb_ack_o,
	output logic                         wb_err_o,
	output soc_pkg::wb_word_u            wb_dat_o,
	// Peripheral side
	input  wire                          gpio_ack_i,
	input  wire                          fifo_ack_i,
	input  wire soc_pkg::wb_word_u       gpio_dat_i,
	input  wire soc_pkg::wb_word_u       fifo_dat_i,
	output logic [soc_pkg::WB_AW-1:0]    req_adr_o,
	output logic [soc_pkg::WB_SW-1:0]    req_sel_o,
	output logic                         req_we_o,
	output soc_pkg::wb_word_u            req_dat_o,
	output logic                         gpio_stb_o,
	output logic                         fifo_stb_o
);

	logic       busy; // One transfer in flight
	logic       accept;
	logic [7:0] region;
	logic       hit_gpio;
	logic       hit_fifo;

	assign region   = wb_adr_i[soc_pkg::REGION_MSB:soc_pkg::REGION_LSB];
	assign hit_gpio = (region == soc_pkg::GPIO_REGION);
	assign hit_fifo = (region == soc_pkg::FIFO_REGION);
	assign accept   = ~busy & wb_cyc_i & wb_stb_i;

	////////////////////////////////////////////////////////////
	// Request stage
	////////////////////////////////////////////////////////////
	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			busy       <= 1'b0;
			gpio_stb_o <= 1'b0;
			fifo_stb_o <= 1'b0;
			wb_err_o   <= 1'b0;
		end else if (accept) begin
			busy       <= 1'b1;
			gpio_stb_o <= hit_gpio;
			fifo_stb_o <= hit_fifo;
			wb_err_o   <= ~hit_gpio & ~hit_fifo; // Unmapped region
		end else if (wb_ack_o || wb_err_o) begin
			busy       <= 1'b0; // Back to idle with the answer
			gpio_stb_o <= 1'b0;
			fifo_stb_o <= 1'b0;
			wb_err_o   <= 1'b0;
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (accept) begin
			req_adr_o <= wb_adr_i;
			req_sel_o <= wb_sel_i;
			req_we_o  <= wb_we_i;
			req_dat_o <= wb_dat_i;
		end
	end

	// Response path straight from the selected peripheral
	assign wb_ack_o = (gpio_stb_o & gpio_ack_i) | (fifo_stb_o & fifo_ack_i);
	assign wb_dat_o = fifo_stb_o ? fifo_dat_i : gpio_dat_i;

endmodule

`default_nettype wire

// File: src/wb_data_resize.sv
`default_nettype none

module wb_data_resize (
	// Word side
	input  wire [soc_pkg::WB_AW-1:0]      adr_i,
	input  wire [soc_pkg::WB_SW-1:0]      sel_i,
	input  wire soc_pkg::wb_word_u        dat_i,
	input  wire                           we_i,
	input  wire                           stb_i,
	output soc_pkg::wb_word_u             dat_o,
	output logic                          ack_o,
	// Byte side
	input  wire [soc_pkg::GPIO_W-1:0]     narrow_dat_i,
	input  wire                           narrow_ack_i,
	output logic                          narrow_adr_o,
	output logic [soc_pkg::GPIO_W-1:0]    narrow_dat_o,
	output logic                          narrow_we_o,
	output logic                          narrow_stb_o
);

	logic [1:0] lane;
	logic [7:0] byte_ofs;

	// Lowest set select bit wins, lane 0 if none
	always_comb begin
		lane = 2'd0;
		for (int i = soc_pkg::WB_SW - 1; i >= 0; i--) begin
			if (sel_i[i])
				lane = 2'(i);
		end
	end

	assign byte_ofs     = {adr_i[7:2], lane};
	assign narrow_adr_o = byte_ofs[0]; // GPIO decodes one offset bit
	assign narrow_dat_o = dat_i.lane[lane];
	assign narrow_we_o  = we_i;
	assign narrow_stb_o = stb_i;

	// Read byte back on every lane
	always_comb begin
		for (int i = 0; i < soc_pkg::WB_SW; i++) begin
			dat_o.lane[i] = narrow_dat_i;
		end
	end

	assign ack_o = narrow_ack_i;

endmodule

`default_nettype wire

// File: src/wb_fifo.sv
`default_nettype none

module wb_fifo (
	input  wire                          wb_clk_i,
	input  wire                          arst_n_i,
	// Bus side
	input  wire [soc_pkg::WB_AW-1:0]     adr_i,
	input  wire soc_pkg::wb_word_u       dat_i,
	input  wire                          we_i,
	input  wire                          stb_i,
	output soc_pkg::wb_word_u            dat_o,
	output logic                         ack_o,
	// Slave to master path
	input  wire soc_pkg::wb_word_u       s2m_dat_i,
	input  wire                          s2m_we_i,
	output logic                         s2m_empty_o,
	output logic                         s2m_full_o,
	// Master to slave path
	input  wire                          m2s_re_i,
	output soc_pkg::wb_word_u            m2s_dat_o,
	output logic                         m2s_empty_o,
	output logic                         m2s_full_o
);

	logic              access;
	logic [5:0]        word_ofs;
	logic              sel_data;
	logic              sel_stat;
	logic              m2s_push;
	logic              s2m_pop;
	soc_pkg::wb_word_u s2m_head;
	soc_pkg::wb_word_u stat_word;

	assign access   = stb_i & ~ack_o;
	assign word_ofs = adr_i[7:2];
	assign sel_data = (word_ofs == soc_pkg::FIFO_REG_DATA);
	assign sel_stat = (word_ofs == soc_pkg::FIFO_REG_STAT);

	assign m2s_push = access & we_i & sel_data;
	assign s2m_pop  = access & ~we_i & sel_data & ~s2m_empty_o;

	always_comb begin
		stat_word.word = '0;
		stat_word.word[soc_pkg::STAT_S2M_EMPTY] = s2m_empty_o;
		stat_word.word[soc_pkg::STAT_S2M_FULL]  = s2m_full_o;
		stat_word.word[soc_pkg::STAT_M2S_EMPTY] = m2s_empty_o;
		stat_word.word[soc_pkg::STAT_M2S_FULL]  = m2s_full_o;
	end

	////////////////////////////////////////////////////////////
	// Bus response
	////////////////////////////////////////////////////////////
	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i)
			ack_o <= 1'b0;
		else
			ack_o <= access; // Single-cycle ack
	end

	always_ff @(posedge wb_clk_i) begin
		if (access && !we_i) begin
			if (sel_data)
				dat_o <= s2m_empty_o ? '0 : s2m_head; // Empty reads as 0
			else if (sel_stat)
				dat_o <= stat_word;
			else
				dat_o <= '0;
		end
	end

	sync_fifo s2m_fifo (
		.wb_clk_i (wb_clk_i),
		.arst_n_i (arst_n_i),
		.wr_i     (s2m_we_i),
		.wr_dat_i (s2m_dat_i),
		.rd_i     (s2m_pop),
		.rd_dat_o (s2m_head),
		.empty_o  (s2m_empty_o),
		.full_o   (s2m_full_o)
	);

	sync_fifo m2s_fifo (
		.wb_clk_i (wb_clk_i),
		.arst_n_i (arst_n_i),
		.wr_i     (m2s_push),
		.wr_dat_i (dat_i),
		.rd_i     (m2s_re_i),
		.rd_dat_o (m2s_dat_o),
		.empty_o  (m2s_empty_o),
		.full_o   (m2s_full_o)
	);

endmodule

`default_nettype wire
